// File: riscv_isa_pkg.sv
/*
 * RV32I instruction encoding
 * Opcodes, instruction word layout, load kinds and field decoders
 */
package riscv_isa_pkg;

  // Data path width, RV32 only
  localparam int XLEN = 32;

  // Write-back PC after reset
  localparam logic [XLEN-1:0] PC_INIT = 'h200;

  // addi x0,x0,0
  localparam logic [31:0] INSTR_NOP = 32'h0000_0013;

  //////////////////////////////
  // Major opcodes, bits 6 to 2
  //////////////////////////////
  localparam logic [6:2] OPC_LOAD     = 5'b00_000;
  localparam logic [6:2] OPC_STORE    = 5'b01_000;
  localparam logic [6:2] OPC_BRANCH   = 5'b11_000;
  localparam logic [6:2] OPC_MISC_MEM = 5'b00_011;
  localparam logic [6:2] OPC_OP       = 5'b01_100;
  localparam logic [6:2] OPC_OP_IMM   = 5'b00_100;
  localparam logic [6:2] OPC_LUI      = 5'b01_101;
  localparam logic [6:2] OPC_STORE_FP = 5'b01_001;

  // Instruction word with pipeline bubble flag
  typedef struct packed {
    logic        bubble;
    logic [31:0] instr;
  } instruction_t;

  // Opcode with funct3, enough to tell load kinds apart
  typedef struct packed {
    logic [2:0] funct3;
    logic [6:2] opcode;
  } opcR_t;

  //////////////////////////////
  // Load kinds
  //////////////////////////////
  localparam opcR_t LB  = '{funct3: 3'b000, opcode: OPC_LOAD};
  localparam opcR_t LH  = '{funct3: 3'b001, opcode: OPC_LOAD};
  localparam opcR_t LW  = '{funct3: 3'b010, opcode: OPC_LOAD};
  localparam opcR_t LBU = '{funct3: 3'b100, opcode: OPC_LOAD};
  localparam opcR_t LHU = '{funct3: 3'b101, opcode: OPC_LOAD};

  // Opcode and funct3 of an instruction word
  function automatic opcR_t decode_opcR(input logic [31:0] instr);
    opcR_t opc;
    opc.funct3 = instr[14:12];
    opc.opcode = instr[6:2];
    return opc;
  endfunction

  // Destination register field
  function automatic logic [4:0] decode_rd(input logic [31:0] instr);
    return instr[11:7];
  endfunction

endpackage

// File: riscv_state_pkg.sv
/*
 * Machine state definitions
 * Exception set, register index type and data memory map
 */
package riscv_state_pkg;

  // Register file index
  typedef logic [4:0] rsd_t;

  // Exception flags, summary bit on top
  typedef struct packed {
    logic any;
    logic store_page_fault;
    logic load_page_fault;
    logic store_access_fault;
    logic load_access_fault;
    logic misaligned_store;
    logic misaligned_load;
    logic breakpoint;
    logic illegal_instruction;
  } exceptions_t;

  //////////////////////////////
  // Data memory map
  //////////////////////////////
  localparam int DMEM_WORDS = 256;
  localparam int DMEM_AW    = $clog2(DMEM_WORDS);

  // First byte address past the RAM, start of access fault region
  localparam logic [31:0] DMEM_LIMIT      = DMEM_WORDS * 4;
  // Everything from here up is unmapped
  localparam logic [31:0] PAGE_FAULT_BASE = 32'h8000_0000;

  // Transfer sizes on the data bus
  localparam logic [1:0] SIZE_BYTE = 2'b00;
  localparam logic [1:0] SIZE_HALF = 2'b01;
  localparam logic [1:0] SIZE_WORD = 2'b10;

endpackage

// File: dmem_if.sv
/*
 * Data memory bus
 * Request from the memory stage, responses from the RAM
 */
`timescale 1ns/1ns

interface dmem_if;
  import riscv_isa_pkg::*;

  // Request side
  logic            req;
  logic            we;
  logic [XLEN-1:0] adr;
  logic [1:0]      size;
  logic [XLEN-1:0] d;

  // Response side, one level per request unless held off
  logic            ack;
  logic            err;
  logic            misaligned;
  logic            page_fault;
  logic [XLEN-1:0] q;

  modport master (output req, we, adr, size, d, input ack, err, misaligned, page_fault, q);
  modport slave (input req, we, adr, size, d, output ack, err, misaligned, page_fault, q);
  // Write-back only looks at responses
  modport observer (input ack, err, misaligned, page_fault, q);
endinterface

// File: memwb_if.sv
/*
 * MEM to WB pipeline register contents
 */
`timescale 1ns/1ns

interface memwb_if;
  import riscv_isa_pkg::*;
  import riscv_state_pkg::*;

  logic [XLEN-1:0] pc;
  instruction_t    insn;
  exceptions_t     exceptions;
  logic [XLEN-1:0] r;
  logic [XLEN-1:0] memadr;

  modport source (output pc, insn, exceptions, r, memadr);
  modport sink (input pc, insn, exceptions, r, memadr);
endinterface

// File: riscv_mem.sv
/*
 * Memory-access stage
 * Registers the execute results and drives the data memory request
 */
`timescale 1ns/1ns

module riscv_mem (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           stall_i,
  input  logic [riscv_isa_pkg::XLEN-1:0] ex_pc_i,
  input  riscv_isa_pkg::instruction_t    ex_insn_i,
  input  riscv_state_pkg::exceptions_t   ex_exceptions_i,
  input  logic [riscv_isa_pkg::XLEN-1:0] ex_r_i,
  input  logic [riscv_isa_pkg::XLEN-1:0] ex_memadr_i,
  input  logic [riscv_isa_pkg::XLEN-1:0] ex_memdata_i,
  dmem_if.master                         dmem,
  memwb_if.source                        mem
);
  import riscv_isa_pkg::*;
  import riscv_state_pkg::*;

  logic [XLEN-1:0] memdata;
  opcR_t           opcR;
  logic            is_load;
  logic            is_store;

  //////////////////////////////
  // Pipeline registers
  //////////////////////////////

  // Control part, comes out of reset as a bubble
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      mem.pc         <= PC_INIT;
      mem.insn       <= '{bubble: 1'b1, instr: INSTR_NOP};
      mem.exceptions <= '0;
    end
    else if (!stall_i)
    begin
      mem.pc         <= ex_pc_i;
      mem.insn       <= ex_insn_i;
      mem.exceptions <= ex_exceptions_i;
    end
  end

  // Payload part
  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      mem.r      <= ex_r_i;
      mem.memadr <= ex_memadr_i;
      memdata    <= ex_memdata_i;
    end
  end

  //////////////////////////////
  // Data memory request
  //////////////////////////////
  assign opcR     = decode_opcR(mem.insn.instr);
  assign is_load  = opcR.opcode == OPC_LOAD;
  assign is_store = opcR.opcode == OPC_STORE;

  // Held until the RAM answers; stall keeps the stage frozen
  assign dmem.req = ~mem.insn.bubble & ~mem.exceptions.any & (is_load | is_store);
  assign dmem.we  = is_store;
  assign dmem.adr = mem.memadr;

  // Size from funct3, store data copied to every lane
  always_comb
  begin
    case (opcR.funct3[1:0])
      2'b00:
      begin
        dmem.size = SIZE_BYTE;
        dmem.d    = {4{memdata[7:0]}};
      end
      2'b01:
      begin
        dmem.size = SIZE_HALF;
        dmem.d    = {2{memdata[15:0]}};
      end
      default:
      begin
        dmem.size = SIZE_WORD;
        dmem.d    = memdata;
      end
    endcase
  end

endmodule

// File: data_ram.sv
/*
 * Data memory
 * Word RAM with byte enables, wait states and fault responses
 */
`timescale 1ns/1ns

module data_ram (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  wait_i,
  dmem_if.slave dmem
);
  import riscv_isa_pkg::*;
  import riscv_state_pkg::*;

  logic [XLEN-1:0]    ram [DMEM_WORDS];
  logic [DMEM_AW-1:0] widx;
  logic [3:0]         be;
  logic               misaligned;
  logic               page_fault;
  logic               access_fault;
  logic               rsp;

  // Contents start cleared
  initial
  begin
    for (int i = 0; i < DMEM_WORDS; i++)
      ram[i] = '0;
  end

  assign widx = dmem.adr[DMEM_AW+1:2];

  //////////////////////////////
  // Fault checks
  //////////////////////////////
  always_comb
  begin
    case (dmem.size)
      SIZE_BYTE: misaligned = 1'b0;
      SIZE_HALF: misaligned = dmem.adr[0];
      default:   misaligned = |dmem.adr[1:0];
    endcase
  end

  assign page_fault   = dmem.adr >= PAGE_FAULT_BASE;
  assign access_fault = (dmem.adr >= DMEM_LIMIT) & ~page_fault;

  // Answer only when not held off
  assign rsp = dmem.req & ~wait_i;

  // Misaligned first, then page fault, then access fault
  assign dmem.misaligned = rsp & misaligned;
  assign dmem.page_fault = rsp & ~misaligned & page_fault;
  assign dmem.err        = rsp & ~misaligned & access_fault;
  assign dmem.ack        = rsp & ~misaligned & ~page_fault & ~access_fault;

  assign dmem.q = ram[widx];

  // Byte enables
  always_comb
  begin
    case (dmem.size)
      SIZE_BYTE: be = 4'b0001 << dmem.adr[1:0];
      SIZE_HALF: be = 4'b0011 << dmem.adr[1:0];
      default:   be = 4'b1111;
    endcase
  end

  // Store on ack only, never while in reset
  always_ff @(posedge clk_i)
  begin
    if (rst_ni && dmem.req && dmem.we && dmem.ack)
    begin
      for (int b = 0; b < 4; b++)
        if (be[b]) ram[widx][8*b +: 8] <= dmem.d[8*b +: 8];
    end
  end

endmodule

// File: riscv_wb.sv
/*
 * Write-back stage
 * Merges memory faults, extends load data, drives the register file write
 */
`timescale 1ns/1ns

module riscv_wb (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  output logic                           stall_o,
  memwb_if.sink                          mem,
  dmem_if.observer                       dmem,
  output logic [riscv_isa_pkg::XLEN-1:0] wb_pc_o,
  output riscv_isa_pkg::instruction_t    wb_insn_o,
  output riscv_state_pkg::exceptions_t   wb_exceptions_o,
  output logic [riscv_isa_pkg::XLEN-1:0] wb_badaddr_o,
  output riscv_state_pkg::rsd_t          wb_dst_o,
  output logic [riscv_isa_pkg::XLEN-1:0] wb_r_o,
  output logic                           wb_we_o
);
  import riscv_isa_pkg::*;
  import riscv_state_pkg::*;

  opcR_t           opcR;
  rsd_t            dst;
  logic            live;
  logic            is_load;
  logic            is_store;
  logic            squash;
  logic            dmem_rsp;
  exceptions_t     exceptions;
  exceptions_t     exc_next;
  logic [XLEN-1:0] badaddr;
  logic [XLEN-1:0] q_shift;
  logic [XLEN-1:0] memq;
  logic            we_next;

  assign opcR     = decode_opcR(mem.insn.instr);
  assign dst      = decode_rd(mem.insn.instr);
  assign live     = ~mem.insn.bubble;
  assign is_load  = opcR.opcode == OPC_LOAD;
  assign is_store = opcR.opcode == OPC_STORE;

  // Instruction right behind a fault gets dropped
  assign squash = wb_exceptions_o.any;

  //////////////////////////////
  // Stall while memory is busy
  //////////////////////////////
  assign dmem_rsp = dmem.ack | dmem.err | dmem.misaligned | dmem.page_fault;
  assign stall_o  = live & ~mem.exceptions.any & (is_load | is_store) & ~dmem_rsp;

  // Fold memory faults into incoming set
  always_comb
  begin
    exceptions = mem.exceptions;
    if (live && is_load)
    begin
      exceptions.misaligned_load   |= dmem.misaligned;
      exceptions.load_access_fault |= dmem.err;
      exceptions.load_page_fault   |= dmem.page_fault;
    end
    if (live && is_store)
    begin
      exceptions.misaligned_store   |= dmem.misaligned;
      exceptions.store_access_fault |= dmem.err;
      exceptions.store_page_fault   |= dmem.page_fault;
    end
    exceptions.any = |exceptions[$bits(exceptions_t)-2:0];
  end

  // Bubbles and squashed slots report nothing
  assign exc_next = (squash || !live) ? '0 : exceptions;

  // Faulting address, or the instruction itself when illegal
  always_comb
  begin
    if (exc_next.misaligned_load   || exc_next.misaligned_store   ||
        exc_next.load_access_fault || exc_next.store_access_fault ||
        exc_next.load_page_fault   || exc_next.store_page_fault   ||
        exc_next.breakpoint)
      badaddr = mem.memadr;
    else if (exc_next.illegal_instruction)
      badaddr = mem.insn.instr;
    else
      badaddr = '0;
  end

  //////////////////////////////
  // Load data alignment
  //////////////////////////////
  assign q_shift = dmem.q >> {mem.memadr[1:0], 3'b000};

  always_comb
  begin
    case (opcR)
      LB:      memq = {{XLEN-8{q_shift[7]}}, q_shift[7:0]};
      LH:      memq = {{XLEN-16{q_shift[15]}}, q_shift[15:0]};
      LW:      memq = dmem.q;
      LBU:     memq = {{XLEN-8{1'b0}}, q_shift[7:0]};
      LHU:     memq = {{XLEN-16{1'b0}}, q_shift[15:0]};
      default: memq = dmem.q;
    endcase
  end

  // Write enable for the register file
  always_comb
  begin
    case (opcR.opcode)
      OPC_STORE, OPC_STORE_FP, OPC_BRANCH, OPC_MISC_MEM: we_next = 1'b0;
      default:                                          we_next = live & |dst;
    endcase
    // No write for faults, squashed slots, or while waiting
    if (exceptions.any || squash || stall_o)
      we_next = 1'b0;
  end

  //////////////////////////////
  // WB registers
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wb_pc_o         <= PC_INIT;
      wb_insn_o       <= '{bubble: 1'b1, instr: INSTR_NOP};
      wb_exceptions_o <= '0;
      wb_badaddr_o    <= '0;
    end
    else if (!stall_o)
    begin
      wb_pc_o          <= mem.pc;
      wb_insn_o.instr  <= mem.insn.instr;
      wb_insn_o.bubble <= mem.insn.bubble | squash;
      wb_exceptions_o  <= exc_next;
      wb_badaddr_o     <= badaddr;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      wb_we_o <= 1'b0;
    else
      wb_we_o <= we_next;
  end

  // Destination and result
  always_ff @(posedge clk_i)
  begin
    if (!stall_o)
    begin
      wb_dst_o <= dst;
      wb_r_o   <= is_load ? memq : mem.r;
    end
  end

endmodule

// File: riscv_rf.sv
/*
 * Integer register file
 * 32 x 32 bits, x0 reads as zero, one observation read port
 */
`timescale 1ns/1ns

module riscv_rf (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           we_i,
  input  riscv_state_pkg::rsd_t          waddr_i,
  input  logic [riscv_isa_pkg::XLEN-1:0] wdata_i,
  input  riscv_state_pkg::rsd_t          raddr_i,
  output logic [riscv_isa_pkg::XLEN-1:0] rdata_o
);
  import riscv_isa_pkg::*;

  logic [XLEN-1:0] regs [32];

  // Cleared on reset, x0 never written
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (we_i && waddr_i != '0)
    begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Hardwired zero
  assign rdata_o = (raddr_i == '0) ? '0 : regs[raddr_i];

endmodule

// File: riscv_memwb_top.sv
/*
 * RV32I pipeline back end
 * MEM and WB stages, data memory and register file
 */
`timescale 1ns/1ns

module riscv_memwb_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic [riscv_isa_pkg::XLEN-1:0] ex_pc_i,
  input  riscv_isa_pkg::instruction_t    ex_insn_i,
  input  riscv_state_pkg::exceptions_t   ex_exceptions_i,
  input  logic [riscv_isa_pkg::XLEN-1:0] ex_r_i,
  input  logic [riscv_isa_pkg::XLEN-1:0] ex_memadr_i,
  input  logic [riscv_isa_pkg::XLEN-1:0] ex_memdata_i,
  input  logic                           dmem_wait_i,
  output logic                           stall_o,
  output logic [riscv_isa_pkg::XLEN-1:0] wb_pc_o,
  output riscv_state_pkg::exceptions_t   wb_exceptions_o,
  output logic [riscv_isa_pkg::XLEN-1:0] wb_badaddr_o,
  output logic                           wb_we_o,
  output riscv_state_pkg::rsd_t          wb_dst_o,
  output logic [riscv_isa_pkg::XLEN-1:0] wb_r_o,
  input  riscv_state_pkg::rsd_t          rf_raddr_i,
  output logic [riscv_isa_pkg::XLEN-1:0] rf_rdata_o
);

  dmem_if  dmem ();
  memwb_if mem ();

  riscv_mem u_mem (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .stall_i         (stall_o),
    .ex_pc_i         (ex_pc_i),
    .ex_insn_i       (ex_insn_i),
    .ex_exceptions_i (ex_exceptions_i),
    .ex_r_i          (ex_r_i),
    .ex_memadr_i     (ex_memadr_i),
    .ex_memdata_i    (ex_memdata_i),
    .dmem            (dmem.master),
    .mem             (mem.source)
  );

  data_ram u_dram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .wait_i (dmem_wait_i),
    .dmem   (dmem.slave)
  );

  riscv_wb u_wb (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .stall_o         (stall_o),
    .mem             (mem.sink),
    .dmem            (dmem.observer),
    .wb_pc_o         (wb_pc_o),
    .wb_insn_o       (),
    .wb_exceptions_o (wb_exceptions_o),
    .wb_badaddr_o    (wb_badaddr_o),
    .wb_dst_o        (wb_dst_o),
    .wb_r_o          (wb_r_o),
    .wb_we_o         (wb_we_o)
  );

  riscv_rf u_rf (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .we_i    (wb_we_o),
    .waddr_i (wb_dst_o),
    .wdata_i (wb_r_o),
    .raddr_i (rf_raddr_i),
    .rdata_o (rf_rdata_o)
  );

endmodule

// File: tb_riscv_memwb.sv
/*
 * Testbench for the RV32I MEM/WB back end
 * Plays the execute stage with LFSR stimulus and checks against a shadow model
 */
`timescale 1ns/1ns

module tb_riscv_memwb;
  import riscv_isa_pkg::*;
  import riscv_state_pkg::*;

  localparam int          CLK_PERIOD   = 20;
  localparam int          RESET_CYCLES = 10;
  localparam int          N_INSNS      = 400;
  localparam int          TIMEOUT_NS   = (RESET_CYCLES + 40 * N_INSNS) * CLK_PERIOD;
  localparam logic [31:0] LFSR_SEED    = 32'h7f7c220a;

  // One execute stage slot
  typedef struct packed {
    logic [XLEN-1:0] pc;
    instruction_t    insn;
    exceptions_t     exc;
    logic [XLEN-1:0] r;
    logic [XLEN-1:0] memadr;
    logic [XLEN-1:0] memdata;
  } ex_item_t;

  logic            clk_i = 1'b0;
  logic            rst_ni;
  logic [XLEN-1:0] ex_pc_i;
  instruction_t    ex_insn_i;
  exceptions_t     ex_exceptions_i;
  logic [XLEN-1:0] ex_r_i;
  logic [XLEN-1:0] ex_memadr_i;
  logic [XLEN-1:0] ex_memdata_i;
  logic            dmem_wait_i;
  logic            stall_o;
  logic [XLEN-1:0] wb_pc_o;
  exceptions_t     wb_exceptions_o;
  logic [XLEN-1:0] wb_badaddr_o;
  logic            wb_we_o;
  rsd_t            wb_dst_o;
  logic [XLEN-1:0] wb_r_o;
  rsd_t            rf_raddr_i;
  logic [XLEN-1:0] rf_rdata_o;

  // Reference model state
  ex_item_t        inflight[$];
  logic [7:0]      shadow_mem [DMEM_WORDS*4];
  logic [XLEN-1:0] shadow_rf [32];
  logic [31:0]     lfsr = LFSR_SEED;
  logic [XLEN-1:0] next_pc = 32'h1000;
  logic            prev_could_fault = 1'b0;
  logic            squash_next = 1'b0;
  int              n_checks = 0;
  int              word_errs = 0;
  int              exc_errs = 0;
  int              reg_errs = 0;
  int              flag_errs = 0;

  riscv_memwb_top uut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ex_pc_i         (ex_pc_i),
    .ex_insn_i       (ex_insn_i),
    .ex_exceptions_i (ex_exceptions_i),
    .ex_r_i          (ex_r_i),
    .ex_memadr_i     (ex_memadr_i),
    .ex_memdata_i    (ex_memdata_i),
    .dmem_wait_i     (dmem_wait_i),
    .stall_o         (stall_o),
    .wb_pc_o         (wb_pc_o),
    .wb_exceptions_o (wb_exceptions_o),
    .wb_badaddr_o    (wb_badaddr_o),
    .wb_we_o         (wb_we_o),
    .wb_dst_o        (wb_dst_o),
    .wb_r_o          (wb_r_o),
    .rf_raddr_i      (rf_raddr_i),
    .rf_rdata_o      (rf_rdata_o)
  );

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  //////////////////////////////
  // Random source
  //////////////////////////////

  // Taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////
  task automatic check_word(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    n_checks++;
    if (got !== exp)
    begin
      word_errs++;
      $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_exc(input string name, input exceptions_t got, input exceptions_t exp);
    n_checks++;
    if (got !== exp)
    begin
      exc_errs++;
      $display("[FAIL] %0t ns %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_reg(input string name, input rsd_t got_idx, input logic [XLEN-1:0] got,
                           input rsd_t exp_idx, input logic [XLEN-1:0] exp);
    n_checks++;
    if (got_idx !== exp_idx || got !== exp)
    begin
      reg_errs++;
      $display("[FAIL] %0t ns %s: got x%0d=%h, expected x%0d=%h",
               $time, name, got_idx, got, exp_idx, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp)
    begin
      flag_errs++;
      $display("[FAIL] %0t ns %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  //////////////////////////////
  // Model rules
  //////////////////////////////

  // Live load or store with a clean incoming set goes to memory
  function automatic logic issues_access(input ex_item_t it);
    logic [6:2] opc;
    opc = it.insn.instr[6:2];
    return !it.insn.bubble && !it.exc.any && (opc == OPC_LOAD || opc == OPC_STORE);
  endfunction

  // Memory side flags from size and address map
  function automatic exceptions_t mem_flags(input logic [31:0] instr, input logic [XLEN-1:0] adr);
    exceptions_t f;
    logic        ld;
    logic        st;
    logic        mis;
    logic        pf;
    f   = '0;
    ld  = instr[6:2] == OPC_LOAD;
    st  = instr[6:2] == OPC_STORE;
    mis = (instr[13:12] == 2'b01) ? adr[0] : (instr[13:12] != 2'b00) && (adr[1:0] != 2'b00);
    pf  = adr >= PAGE_FAULT_BASE;
    if (mis)
    begin
      f.misaligned_load  = ld;
      f.misaligned_store = st;
    end
    else if (pf)
    begin
      f.load_page_fault  = ld;
      f.store_page_fault = st;
    end
    else if (adr >= 32'(DMEM_WORDS * 4))
    begin
      f.load_access_fault  = ld;
      f.store_access_fault = st;
    end
    f.any = |f[7:0];
    return f;
  endfunction

  // Load result built from shadow bytes
  function automatic logic [XLEN-1:0] load_value(input logic [2:0] f3, input logic [9:0] a);
    logic [7:0] b0;
    logic [7:0] b1;
    b0 = shadow_mem[a];
    b1 = shadow_mem[a + 10'd1];
    case (f3)
      3'b000:  return {{24{b0[7]}}, b0};
      3'b001:  return {{16{b1[7]}}, b1, b0};
      3'b100:  return {24'd0, b0};
      3'b101:  return {16'd0, b1, b0};
      default: return {shadow_mem[a + 10'd3], shadow_mem[a + 10'd2], b1, b0};
    endcase
  endfunction

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Address in RAM, access fault or page fault region with size-aligned offset
  task automatic gen_addr(input logic [1:0] sz, output logic [XLEN-1:0] adr);
    logic [2:0] region;
    logic [1:0] off;
    region = 3'(rand_bits(3));
    case (sz)
      2'b00:   off = 2'(rand_bits(2));
      2'b01:   off = {1'(rand_bits(1)), 1'b0};
      default: off = 2'b00;
    endcase
    // Region 5 takes any offset and often misaligns
    if (region == 3'd5)
      off = 2'(rand_bits(2));
    case (region)
      3'd6:    adr = 32'h400 + {12'd0, 18'(rand_bits(18)), off};
      3'd7:    adr = {1'b1, 29'(rand_bits(29)), off};
      default: adr = {22'd0, 1'(rand_bits(1)), 2'b00, 5'(rand_bits(5)), off};
    endcase
  endtask

  task automatic gen_item(output ex_item_t it);
    logic [2:0]  kind;
    logic [2:0]  sel;
    logic [2:0]  f3;
    logic [6:2]  opc;
    rsd_t        rd;
    exceptions_t mf;
    it   = '0;
    kind = 3'(rand_bits(3));
    sel  = 3'(rand_bits(3));
    rd   = rsd_t'(rand_bits(5));
    if (3'(rand_bits(3)) == 3'd0)
      rd = '0;
    f3  = 3'(rand_bits(3));
    opc = OPC_OP_IMM;
    case (kind)
      3'd0, 3'd1: opc = (sel[1:0] == 2'd0) ? OPC_LUI : (sel[0] ? OPC_OP : OPC_OP_IMM);
      3'd4:       opc = OPC_STORE;
      3'd5:       opc = sel[0] ? OPC_BRANCH : OPC_MISC_MEM;
      3'd6:       opc = sel[0] ? OPC_LOAD : OPC_OP;
      3'd7:       opc = sel[2] ? OPC_STORE : OPC_LOAD;
      default:    opc = OPC_LOAD;
    endcase
    // Stores stay out of slots that a fault would squash
    if (opc == OPC_STORE && prev_could_fault)
      opc = OPC_OP;
    if (opc == OPC_LOAD)
    begin
      case (sel)
        3'd0:    f3 = LB.funct3;
        3'd1:    f3 = LH.funct3;
        3'd3:    f3 = LBU.funct3;
        3'd4:    f3 = LHU.funct3;
        3'd5:    f3 = LBU.funct3;
        3'd6:    f3 = LHU.funct3;
        default: f3 = LW.funct3;
      endcase
    end
    else if (opc == OPC_STORE)
      f3 = (sel[1:0] == 2'd3) ? 3'b010 : {1'b0, sel[1:0]};
    it.insn.instr = {17'(rand_bits(17)), f3, rd, opc, 2'b11};
    it.insn.bubble = 3'(rand_bits(3)) == 3'd0;
    it.pc      = next_pc;
    next_pc    = next_pc + 32'd4;
    it.r       = rand_bits(32);
    it.memdata = rand_bits(32);
    if (opc == OPC_LOAD || opc == OPC_STORE)
      gen_addr(f3[1:0], it.memadr);
    else
      it.memadr = rand_bits(32);
    // Incoming illegal instruction or breakpoint
    if (kind == 3'd6 && !it.insn.bubble)
    begin
      it.exc.illegal_instruction = sel[1];
      it.exc.breakpoint          = !sel[1];
      it.exc.any                 = 1'b1;
    end
    mf = mem_flags(it.insn.instr, it.memadr);
    prev_could_fault = !it.insn.bubble && (it.exc.any || mf.any);
  endtask

  task automatic make_bubble(output ex_item_t it);
    it             = '0;
    it.insn.bubble = 1'b1;
    it.insn.instr  = INSTR_NOP;
    it.pc          = next_pc;
    prev_could_fault = 1'b0;
  endtask

  task automatic drive_item(input ex_item_t it);
    ex_pc_i         = it.pc;
    ex_insn_i       = it.insn;
    ex_exceptions_i = it.exc;
    ex_r_i          = it.r;
    ex_memadr_i     = it.memadr;
    ex_memdata_i    = it.memdata;
  endtask

  // Predict and check one instruction entering WB and update shadows
  task automatic retire(input ex_item_t it);
    exceptions_t     memf;
    exceptions_t     exc;
    logic            live;
    logic            req;
    logic            writes;
    logic            we_exp;
    logic [6:2]      opc;
    rsd_t            rd;
    logic [XLEN-1:0] badaddr;
    logic [XLEN-1:0] wdata;
    int              nbytes;
    live   = !it.insn.bubble;
    opc    = it.insn.instr[6:2];
    rd     = it.insn.instr[11:7];
    req    = issues_access(it);
    memf   = req ? mem_flags(it.insn.instr, it.memadr) : '0;
    exc    = it.exc | memf;
    exc.any = |exc[7:0];
    writes = !(opc == OPC_STORE || opc == OPC_STORE_FP || opc == OPC_BRANCH ||
               opc == OPC_MISC_MEM);
    we_exp = live && writes && rd != '0 && !exc.any && !squash_next;
    if (squash_next || !live)
      exc = '0;
    // Memory faults and breakpoint report the data address
    if (|exc[7:1])
      badaddr = it.memadr;
    else if (exc.illegal_instruction)
      badaddr = it.insn.instr;
    else
      badaddr = '0;
    wdata = (opc == OPC_LOAD) ? load_value(it.insn.instr[14:12], it.memadr[9:0]) : it.r;
    check_word("wb_pc_o", wb_pc_o, it.pc);
    check_exc("wb_exceptions_o", wb_exceptions_o, exc);
    check_word("wb_badaddr_o", wb_badaddr_o, badaddr);
    check_flag("wb_we_o", wb_we_o, we_exp);
    if (we_exp)
    begin
      check_reg("wb_dst_o/wb_r_o", wb_dst_o, wb_r_o, rd, wdata);
      shadow_rf[rd] = wdata;
    end
    if (req && opc == OPC_STORE && !memf.any)
    begin
      nbytes = (it.insn.instr[13:12] == 2'b00) ? 1 : (it.insn.instr[13:12] == 2'b01) ? 2 : 4;
      for (int b = 0; b < nbytes; b++)
        shadow_mem[it.memadr[9:0] + 10'(b)] = it.memdata[8*b +: 8];
    end
    squash_next = exc.any;
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial
  begin
    ex_item_t cur;
    ex_item_t rst_bubble;
    logic     stall_seen;
    int       n_retired;
    n_retired = 0;
    for (int i = 0; i < DMEM_WORDS * 4; i++)
      shadow_mem[i] = 8'h00;
    for (int i = 0; i < 32; i++)
      shadow_rf[i] = '0;
    rst_ni      = 1'b0;
    dmem_wait_i = 1'b0;
    rf_raddr_i  = '0;
    make_bubble(cur);
    drive_item(cur);
    repeat (RESET_CYCLES) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // Reset state of WB
    check_flag("wb_we_o", wb_we_o, 1'b0);
    check_exc("wb_exceptions_o", wb_exceptions_o, '0);
    check_word("wb_pc_o", wb_pc_o, PC_INIT);

    // MEM holds its reset bubble
    rst_bubble             = '0;
    rst_bubble.pc          = PC_INIT;
    rst_bubble.insn.bubble = 1'b1;
    rst_bubble.insn.instr  = INSTR_NOP;
    inflight.push_back(rst_bubble);
    gen_item(cur);
    drive_item(cur);

    while (n_retired < N_INSNS + 1)
    begin
      @(negedge clk_i);
      stall_seen = stall_o;
      check_flag("stall_o", stall_o, issues_access(inflight[0]) && dmem_wait_i);
      @(posedge clk_i);
      #1;
      if (!stall_seen)
      begin
        retire(inflight.pop_front());
        inflight.push_back(cur);
        n_retired++;
      end
      else
        check_flag("wb_we_o", wb_we_o, 1'b0);
      #1;
      if (!stall_seen)
      begin
        if (n_retired < N_INSNS)
          gen_item(cur);
        else
          make_bubble(cur);
        drive_item(cur);
      end
      dmem_wait_i = 2'(rand_bits(2)) == 2'd0;
    end

    // Drain the pipeline and read back every register
    dmem_wait_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #2;
    for (int i = 0; i < 32; i++)
    begin
      rf_raddr_i = rsd_t'(i);
      #1;
      check_reg("rf_rdata_o", rf_raddr_i, rf_rdata_o, rsd_t'(i), shadow_rf[i]);
    end

    $display("Checks %0d, errors: word %0d, exceptions %0d, register %0d, flag %0d",
             n_checks, word_errs, exc_errs, reg_errs, flag_errs);
    if (word_errs + exc_errs + reg_errs + flag_errs == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  // Watchdog allows 40 cycles per instruction plus reset
  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns, the pipeline stopped making progress", TIMEOUT_NS);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: src.f
riscv_isa_pkg.sv
riscv_state_pkg.sv
dmem_if.sv
memwb_if.sv
riscv_mem.sv
data_ram.sv
riscv_wb.sv
riscv_rf.sv
riscv_memwb_top.sv
tb_riscv_memwb.sv

// File: Makefile
# Verilator build and run of the MEM/WB back end testbench

VERILATOR := verilator
VFLAGS    := --binary -j 0 --timescale 1ns/1ns
TOP       := tb_riscv_memwb
FILELIST  := src.f

SRCS := $(shell cat $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
